// File: Makefile
# Verilator flow for the npc core testbench

TOP       ?= npc_core_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= run.log
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, not the exit status of the binary
run: compile
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test OK" $(LOG); then \
		echo "PASS: $(TOP)"; \
	else \
		echo "FAIL: $(TOP), see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/npc_core.sv
`timescale 1ns/1ps
`default_nettype none

module npc_core
    import npc_isa_pkg::*;
    import npc_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  inst_t inst,         // From instruction memory, same cycle
    output word_t inst_addr,
    output wb_s   wb,           // Writeback report, also the RF write
    output logic  halted
);

    word_t       pc;
    core_state_e state;
    core_state_e exu_state;     // Execute sees HALT while in reset
    dec_s        dec;
    word_t       rdata1;
    word_t       rdata2;
    logic        jump;
    word_t       jump_target;
    logic        halt_req;

    // --------------------
    // Fetch
    // --------------------
    npc_ifu u_ifu (
        .clk         (clk),
        .arst_n      (arst_n),
        .jump        (jump),
        .jump_target (jump_target),
        .halt_req    (halt_req),
        .pc          (pc),
        .state       (state)
    );

    assign inst_addr = pc;

    // --------------------
    // Decode and operands
    // --------------------
    npc_idu u_idu (
        .inst (inst),
        .dec  (dec)
    );

    npc_regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .rs1    (dec.rs1),
        .rs2    (dec.rs2),
        .wr     (wb),           // Written at the end of the cycle
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    // --------------------
    // Execute
    // --------------------
    // No writeback, jump or halt request while arst_n is low
    assign exu_state = arst_n ? state : CORE_HALT;

    npc_exu u_exu (
        .dec         (dec),
        .pc          (pc),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .state       (exu_state),
        .wb          (wb),
        .jump        (jump),
        .jump_target (jump_target),
        .halt_req    (halt_req)
    );

    assign halted = (state == CORE_HALT);   // Rises one edge after ebreak

endmodule

`default_nettype wire

// File: design/npc_ctrl_pkg.sv
`default_nettype none

package npc_ctrl_pkg;

    import npc_isa_pkg::*;

    // --------------------
    // Decode
    // --------------------
    // One code per supported instruction
    typedef enum logic [2:0] {
        KIND_NONE   = 3'd0,  // Unknown encoding, executes as a no-op
        KIND_ADDI   = 3'd1,
        KIND_JALR   = 3'd2,
        KIND_EBREAK = 3'd3,
        KIND_ADD    = 3'd4,
        KIND_LUI    = 3'd5
    } inst_kind_e;

    // Everything the execute stage needs from the instruction word
    typedef struct packed {
        inst_kind_e kind;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      imm;   // Already sign extended or shifted
    } dec_s;

    // --------------------
    // Writeback and state
    // --------------------
    typedef struct packed {
        logic     valid;   // Write this cycle
        reg_idx_t rd;
        word_t    data;
    } wb_s;

    typedef enum logic {
        CORE_RUN  = 1'b0,
        CORE_HALT = 1'b1   // Entered on ebreak, left only by reset
    } core_state_e;

endpackage

`default_nettype wire

// File: design/npc_exu.sv
`timescale 1ns/1ps
`default_nettype none

module npc_exu
    import npc_isa_pkg::*;
    import npc_ctrl_pkg::*;
(
    input  dec_s        dec,
    input  word_t       pc,
    input  word_t       rdata1,
    input  word_t       rdata2,
    input  core_state_e state,
    output wb_s         wb,
    output logic        jump,
    output word_t       jump_target,
    output logic        halt_req
);

    word_t sum_imm;     // rs1 + imm, addi and jalr
    word_t sum_reg;     // rs1 + rs2
    word_t link;        // Return address
    logic  run;

    assign run     = (state == CORE_RUN);
    assign sum_imm = rdata1 + dec.imm;
    assign sum_reg = rdata1 + rdata2;
    assign link    = pc + INST_BYTES;

    // --------------------
    // Per-kind result
    // --------------------
    always_comb begin
        wb          = '0;
        jump        = 1'b0;
        jump_target = '0;
        halt_req    = 1'b0;
        if (run) begin                // Nothing leaves while halted
            case (dec.kind)
                KIND_ADDI: begin
                    wb = '{valid: 1'b1, rd: dec.rd, data: sum_imm};
                end
                KIND_ADD: begin
                    wb = '{valid: 1'b1, rd: dec.rd, data: sum_reg};
                end
                KIND_LUI: begin
                    wb = '{valid: 1'b1, rd: dec.rd, data: dec.imm};
                end
                KIND_JALR: begin
                    wb          = '{valid: 1'b1, rd: dec.rd, data: link};
                    jump        = 1'b1;
                    jump_target = {sum_imm[31:1], 1'b0};  // LSB forced low
                end
                KIND_EBREAK: begin
                    halt_req = 1'b1;  // No register write
                end
                default: begin
                    // Unknown word, plain PC+4
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/npc_idu.sv
`timescale 1ns/1ps
`default_nettype none

module npc_idu
    import npc_isa_pkg::*;
    import npc_ctrl_pkg::*;
(
    input  inst_t inst,
    output dec_s  dec
);

    opcode_t    opcode;
    funct3_t    funct3;
    funct7_t    funct7;
    word_t      imm_i;      // I-type, sign extended
    word_t      imm_u;      // U-type, upper 20 bits
    word_t      imm;
    inst_kind_e kind;

    // --------------------
    // Field extraction
    // --------------------
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};

    // --------------------
    // Instruction match
    // --------------------
    always_comb begin
        kind = KIND_NONE;     // Anything unmatched is a no-op
        case (opcode)
            OPC_OP_IMM: begin
                if (funct3 == F3_ADD) begin
                    kind = KIND_ADDI;
                end
            end
            OPC_JALR: begin
                if (funct3 == F3_JALR) begin
                    kind = KIND_JALR;
                end
            end
            OPC_OP: begin
                // sub and the rest share this opcode
                if (funct3 == F3_ADD && funct7 == F7_ADD) begin
                    kind = KIND_ADD;
                end
            end
            OPC_LUI: begin
                kind = KIND_LUI;
            end
            OPC_SYSTEM: begin
                if (inst == INST_EBREAK) begin
                    kind = KIND_EBREAK;   // Exact word only
                end
            end
            default: begin
                kind = KIND_NONE;
            end
        endcase
    end

    // Immediate format follows the kind
    always_comb begin
        case (kind)
            KIND_ADDI,
            KIND_JALR: imm = imm_i;
            KIND_LUI:  imm = imm_u;
            default:   imm = '0;      // R-type and no-ops
        endcase
    end

    // --------------------
    // Output bundle
    // --------------------
    assign dec.kind = kind;
    assign dec.rd   = inst[11:7];
    assign dec.rs1  = inst[19:15];
    assign dec.rs2  = inst[24:20];
    assign dec.imm  = imm;

endmodule

`default_nettype wire

// File: design/npc_ifu.sv
`timescale 1ns/1ps
`default_nettype none

module npc_ifu
    import npc_isa_pkg::*;
    import npc_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        jump,         // Take jump_target this cycle
    input  word_t       jump_target,
    input  logic        halt_req,     // ebreak in execute
    output word_t       pc,
    output core_state_e state
);

    core_state_e state_q;
    core_state_e state_d;
    word_t       pc_q;
    word_t       pc_d;
    word_t       pc_seq;             // Fall-through address

    assign pc_seq = pc_q + INST_BYTES;

    // --------------------
    // Next PC and state
    // --------------------
    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        case (state_q)
            CORE_RUN: begin
                if (halt_req) begin
                    state_d = CORE_HALT;      // PC stays on the ebreak
                end else if (jump) begin
                    pc_d = jump_target;       // jalr
                end else begin
                    pc_d = pc_seq;
                end
            end
            CORE_HALT: begin
                // Sticky until reset
                state_d = CORE_HALT;
            end
            default: begin
                state_d = CORE_RUN;
            end
        endcase
    end

    // --------------------
    // Registers
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= CORE_RUN;
            pc_q    <= RESET_PC;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
        end
    end

    assign pc    = pc_q;      // Also the fetch address
    assign state = state_q;

endmodule

`default_nettype wire

// File: design/npc_isa_pkg.sv
`default_nettype none

package npc_isa_pkg;

    // --------------------
    // Basic widths
    // --------------------
    typedef logic [31:0] word_t;       // Data or address word
    typedef logic [31:0] inst_t;       // Raw instruction word
    typedef logic [4:0]  reg_idx_t;    // Architectural register index
    typedef logic [6:0]  opcode_t;     // inst[6:0]
    typedef logic [2:0]  funct3_t;     // inst[14:12]
    typedef logic [6:0]  funct7_t;     // inst[31:25]

    // --------------------
    // Encodings
    // --------------------
    localparam opcode_t OPC_OP_IMM = 7'b0010011;  // addi and friends
    localparam opcode_t OPC_OP     = 7'b0110011;  // Register-register ALU
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;  // ecall, ebreak, CSRs

    localparam funct3_t F3_ADD  = 3'b000;  // Shared by addi and add
    localparam funct3_t F3_JALR = 3'b000;
    localparam funct7_t F7_ADD  = 7'b0000000;  // sub would be 0100000

    // Whole ebreak word, nothing else in SYSTEM is supported
    localparam inst_t INST_EBREAK = 32'h0010_0073;

    // --------------------
    // Core constants
    // --------------------
    localparam word_t RESET_PC   = 32'h8000_0000;  // First fetch address
    localparam int    NUM_REGS   = 32;             // x0 .. x31
    localparam word_t INST_BYTES = 32'd4;          // Sequential PC step

endpackage

`default_nettype wire

// File: design/npc_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module npc_regfile
    import npc_isa_pkg::*;
    import npc_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  wb_s      wr,       // Write port straight from execute
    output word_t    rdata1,
    output word_t    rdata2
);

    // x0 has no storage
    word_t regs [1:NUM_REGS-1];

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && (wr.rd != '0)) begin
            regs[wr.rd] <= wr.data;   // Writes to x0 dropped
        end
    end

    // --------------------
    // Read ports
    // --------------------
    // Combinational, no bypass needed in a single-cycle core
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: sources.f
design/npc_isa_pkg.sv
design/npc_ctrl_pkg.sv
design/npc_ifu.sv
design/npc_idu.sv
design/npc_regfile.sv
design/npc_exu.sv
design/npc_core.sv
tb/npc_core_tb.sv

// File: tb/npc_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module npc_core_tb
    import npc_isa_pkg::*;
    import npc_ctrl_pkg::*;
();

    localparam int         CLK_HALF     = 20;        // 40 ns period
    localparam int         RESET_CYCLES = 16;
    localparam int         DRIVE_DLY    = 1;         // After the rising edge
    localparam int         FETCH_DLY    = 2;         // Memory answers after the PC moves
    localparam int         WAIT_LIMIT   = 32;        // Cycles per expected event
    localparam int         HOLD_CYCLES  = 4;         // Checked after halt
    localparam int         IMEM_WORDS   = 64;
    localparam word_t      IMEM_BYTES   = 32'd256;
    localparam int         MAX_RECS     = 64;
    localparam logic [3:0] REC_END      = 4'd0;
    localparam logic [3:0] REC_INST     = 4'd1;
    localparam logic [3:0] REC_WB       = 4'd2;
    localparam logic [3:0] REC_JUMP     = 4'd3;
    localparam logic [3:0] REC_HALT     = 4'd4;

    // One line of the data file
    typedef struct packed {
        logic [3:0] kind;
        word_t      a;     // Address or rd
        word_t      b;     // Instruction or data
    } test_rec_s;

    logic        clk;
    logic        arst_n;
    inst_t       inst;
    word_t       inst_addr;
    wb_s         wb;
    logic        halted;
    inst_t       imem [0:IMEM_WORDS-1];
    logic [67:0] raw_recs [0:MAX_RECS-1];
    test_rec_s   exp_q [$];            // Writeback, jump and halt records in order
    word_t       exp_pc;

    npc_core DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .inst      (inst),
        .inst_addr (inst_addr),
        .wb        (wb),
        .halted    (halted)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    // --------------------
    // Reporting
    // --------------------
    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // --------------------
    // Memory contents
    // --------------------
    // Opcodes this core leaves undecoded
    function automatic logic [6:0] noop_opcode(input logic [1:0] sel);
        case (sel)
            2'd0:    return 7'b0000011;   // LOAD
            2'd1:    return 7'b0100011;   // STORE
            2'd2:    return 7'b1100011;   // BRANCH
            default: return 7'b1101111;   // JAL
        endcase
    endfunction

    function automatic inst_t fill_word(input word_t addr);
        word_t mix;
        mix = $urandom ^ addr ^ {addr[6:0], addr[31:7]};
        return {mix[31:7], noop_opcode(mix[1:0])};
    endfunction

    task automatic load_tests();
        test_rec_s rec;
        word_t     off;
        logic      done;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i[5:0]] = fill_word(RESET_PC + (word_t'(i) << 2));
        end
        for (int i = 0; i < MAX_RECS; i++) begin
            raw_recs[i[5:0]] = '0;                // Unused lines read as end
        end
        $readmemh("tb/npc_tests.mem", raw_recs);
        done = 1'b0;
        for (int i = 0; i < MAX_RECS; i++) begin
            rec = test_rec_s'(raw_recs[i[5:0]]);
            if (rec.kind == REC_END) begin
                done = 1'b1;
            end
            if (!done) begin
                case (rec.kind)
                    REC_INST: begin
                        off = rec.a - RESET_PC;
                        if (off >= IMEM_BYTES || off[1:0] != 2'b00) begin
                            stop_on_failure($sformatf(
                                "Program word %0d at 0x%08h lies outside the memory", i, rec.a));
                        end
                        imem[off[7:2]] = rec.b;
                    end
                    REC_WB, REC_JUMP, REC_HALT: exp_q.push_back(rec);
                    default: stop_on_failure($sformatf("Record %0d has an unknown kind", i));
                endcase
            end
        end
    endtask

    // Combinational instruction port, answered a little after each edge
    // Served in reset too, so the first program word sits on the bus
    initial begin
        word_t off;
        inst = '0;
        forever begin
            @(posedge clk);
            #FETCH_DLY;
            off = inst_addr - RESET_PC;
            if (off >= IMEM_BYTES) begin
                stop_on_failure($sformatf("Fetch from 0x%08h is outside the memory", inst_addr));
            end else begin
                inst = imem[off[7:2]];
            end
        end
    end

    // --------------------
    // Expected events
    // --------------------
    task automatic wait_writeback(input int n, input test_rec_s rec);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(negedge clk);
            check_val("inst_addr", inst_addr, exp_pc);
            check_val("halted", 32'(halted), 32'd0);
            if (wb.valid) begin
                check_val("wb.rd", 32'(wb.rd), rec.a);
                check_val("wb.data", wb.data, rec.b);
                seen = 1'b1;
            end else begin
                exp_pc = exp_pc + INST_BYTES;     // Undecoded word
                cycles++;
                if (cycles > WAIT_LIMIT) begin
                    stop_on_failure($sformatf("Timeout: writeback %0d to x%0d was never seen",
                                              n, rec.a));
                end
            end
        end
    endtask

    task automatic wait_halt(input int n, input test_rec_s rec);
        int   cycles;
        logic seen;
        logic at_break;
        cycles   = 0;
        seen     = 1'b0;
        at_break = 1'b0;
        while (!seen) begin
            @(negedge clk);
            check_val("halted", 32'(halted), 32'(at_break));  // One edge after ebreak
            if (halted) begin
                check_val("inst_addr", inst_addr, rec.a);
                seen = 1'b1;
            end else begin
                check_val("inst_addr", inst_addr, exp_pc);
                check_val("wb.valid", 32'(wb.valid), 32'd0);
                at_break = (inst_addr == rec.a);
                exp_pc   = exp_pc + INST_BYTES;
                cycles++;
                if (cycles > WAIT_LIMIT) begin
                    stop_on_failure($sformatf("Timeout: halt record %0d at 0x%08h was never seen",
                                              n, rec.a));
                end
            end
        end
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_val("inst_addr", inst_addr, rec.a);   // PC frozen
            check_val("halted", 32'(halted), 32'd1);
            check_val("wb.valid", 32'(wb.valid), 32'd0);
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int k;
        void'($urandom(32'h6d2c980c));
        arst_n = 1'b0;
        exp_pc = RESET_PC;
        load_tests();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_val("inst_addr", inst_addr, RESET_PC);
            check_val("halted", 32'(halted), 32'd0);
            check_val("wb.valid", 32'(wb.valid), 32'd0);
        end
        @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;
        k = 0;
        while (k < exp_q.size()) begin
            case (exp_q[k].kind)
                REC_WB: begin
                    wait_writeback(k, exp_q[k]);
                    if (k + 1 < exp_q.size() && exp_q[k+1].kind == REC_JUMP) begin
                        exp_pc = exp_q[k+1].a;   // jalr target
                        k = k + 2;
                    end else begin
                        exp_pc = exp_pc + INST_BYTES;
                        k = k + 1;
                    end
                end
                REC_HALT: begin
                    wait_halt(k, exp_q[k]);
                    k = k + 1;
                end
                default: begin
                    stop_on_failure($sformatf("Jump record %0d does not follow a writeback", k));
                end
            endcase
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/npc_tests.mem
// Columns: kind, address or rd, instruction or data
// kind 1 program word, 2 writeback, 3 next fetch address, 4 halt at address
// lui x1, 0x12345
1_80000000_123450b7
2_00000001_12345000
// addi x2, x1, 0x678
1_80000004_67808113
2_00000002_12345678
// addi x3, x2, -1
1_80000008_fff10193
2_00000003_12345677
// add x4, x2, x3
1_8000000c_00310233
2_00000004_2468acef
// addi x6, x0, -1
1_80000010_fff00313
2_00000006_ffffffff
// addi x7, x6, 16 wraps around
1_80000014_01030393
2_00000007_0000000f
// add x8, x6, x1
1_80000018_00130433
2_00000008_12344fff
// 0x8000001c stays a random no-op
// addi x0, x1, 0x123 still reported
1_80000020_12308013
2_00000000_12345123
// add x9, x0, x4
1_80000024_004004b3
2_00000009_2468acef
// lui x10, 0x80000
1_80000028_80000537
2_0000000a_80000000
// jalr x11, 0x41(x10) with odd target
1_8000002c_041505e7
2_0000000b_80000030
3_80000040_00000000
// add x12, x11, x0
1_80000040_00058633
2_0000000c_80000030
// Two random no-ops, then jalr x13, 0x58(x10)
1_8000004c_058506e7
2_0000000d_80000050
3_80000058_00000000
// addi x14, x13, -16
1_80000058_ff068713
2_0000000e_80000040
// Random no-op at 0x8000005c, then ebreak
1_80000060_00100073
4_80000060_00000000
